/* verilog/processerPkg.sv */
//------------------------------
// Processer shared definitions
// Pixel width, command opcodes, parser states
//------------------------------
`default_nettype none

package processerPkg;

    // RGB888 pixel, red in the top byte
    localparam int pixelWidth = 24;

    // First byte of every 4-byte host command
    typedef enum logic [7:0] {
        cmdStop    = 8'h00,     // Halt once current frame is out
        cmdSolid   = 8'h01,     // Whole frame in one colour
        cmdBars    = 8'h02,     // Eight vertical bars, colour bytes unused
        cmdChecker = 8'h03      // 8x8 tiles, colour and its inverse
    } commandOp;

    // Parser to generator mode, same encoding as the opcode
    typedef commandOp pictureMode;

    // Command parser FSM
    typedef enum logic [1:0] {
        waitOp,                 // Expecting opcode byte
        waitRed,
        waitGreen,
        waitBlue                // Last byte, fires update
    } parserState;

endpackage

`default_nettype wire

/* verilog/pixelStreamIf.sv */
//------------------------------
// Pixel stream bus
// Valid/ready pixels with frame-start flag
//------------------------------
`timescale 1ns/100ps
`default_nettype none

interface pixelStreamIf;
    import processerPkg::*;

    logic [pixelWidth-1:0] pixel;   // RGB payload
    logic                  first;   // First pixel of a frame
    logic                  valid;
    logic                  ready;   // FIFO not full

    // Generator side
    modport source (
        output pixel,
        output first,
        output valid,
        input  ready
    );

    // FIFO side
    modport sink (
        input  pixel,
        input  first,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

/* verilog/uartReceiver.sv */
//------------------------------
// UART receiver
// 8N1 serial line to byte strobes
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module uartReceiver #(
    parameter int clkDiv = 868          // System clocks per bit
)(
    input  wire        sysClk,
    input  wire        reset,
    input  wire        uartRx,          // Idle high line
    output logic [7:0] rxByte,
    output logic       rxStrobe         // One cycle per received byte
);

    localparam int cntWidth = $clog2(clkDiv);

    typedef enum logic [1:0] {
        rxIdle,
        rxStart,
        rxData,
        rxStop
    } uartState;

    uartState            state;
    logic [1:0]          rxSync;        // Metastability guard
    logic [cntWidth-1:0] bitTimer;      // Counts down to next sample point
    logic [2:0]          bitIndex;
    logic                timerDone;

    assign timerDone = bitTimer == '0;

    //------------------------------
    // Bit timing and framing
    //------------------------------
    always_ff @(posedge sysClk)
    begin
        if (reset)
        begin
            state    <= rxIdle;
            rxSync   <= 2'b11;
            bitTimer <= '0;
            bitIndex <= '0;
            rxStrobe <= 1'b0;
        end
        else
        begin
            rxSync   <= {rxSync[0], uartRx};
            rxStrobe <= 1'b0;
            if (!timerDone)
                bitTimer <= bitTimer - 1'b1;
            case (state)
                rxIdle:
                    if (!rxSync[1])                     // Falling edge of start bit
                    begin
                        bitTimer <= cntWidth'(clkDiv / 2 - 1);
                        state    <= rxStart;
                    end
                rxStart:
                    if (timerDone)
                    begin
                        bitTimer <= cntWidth'(clkDiv - 1);
                        bitIndex <= '0;
                        state    <= rxSync[1] ? rxIdle : rxData; // Glitch check
                    end
                rxData:
                    if (timerDone)
                    begin
                        bitTimer <= cntWidth'(clkDiv - 1);
                        bitIndex <= bitIndex + 1'b1;
                        if (bitIndex == 3'd7)
                            state <= rxStop;
                    end
                rxStop:
                    if (timerDone)
                    begin
                        rxStrobe <= rxSync[1];          // Framing error drops the byte
                        state    <= rxIdle;
                    end
                default: state <= rxIdle;
            endcase
        end
    end

    // LSB arrives first, shift in from the top
    always_ff @(posedge sysClk)
    begin
        if (state == rxData && timerDone)
            rxByte <= {rxSync[1], rxByte[7:1]};
    end

endmodule

`default_nettype wire

/* verilog/commandParser.sv */
//------------------------------
// Command parser
// Opcode plus RGB bytes into picture setting
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module commandParser (
    input  wire                                 sysClk,
    input  wire                                 reset,
    input  wire  [7:0]                          rxByte,
    input  wire                                 rxStrobe,
    output processerPkg::pictureMode            mode,
    output logic [processerPkg::pixelWidth-1:0] color,
    output logic                                update     // Pulse after blue byte
);
    import processerPkg::*;

    parserState state;
    commandOp   opcode;     // Held until blue arrives
    logic [7:0] red;
    logic [7:0] green;
    logic       knownOp;

    // Only the four defined opcodes start a command
    always_comb
    begin
        case (rxByte)
            cmdStop, cmdSolid, cmdBars, cmdChecker: knownOp = 1'b1;
            default:                                knownOp = 1'b0;
        endcase
    end

    //------------------------------
    // Command FSM
    //------------------------------
    always_ff @(posedge sysClk)
    begin
        if (reset)
        begin
            state  <= waitOp;
            mode   <= cmdStop;
            update <= 1'b0;
        end
        else
        begin
            update <= 1'b0;
            if (rxStrobe)
            begin
                case (state)
                    waitOp:    if (knownOp) state <= waitRed;  // Junk stays here
                    waitRed:   state <= waitGreen;
                    waitGreen: state <= waitBlue;
                    waitBlue:
                    begin
                        state  <= waitOp;
                        mode   <= opcode;
                        update <= 1'b1;
                    end
                    default:   state <= waitOp;
                endcase
            end
        end
    end

    // Byte capture
    always_ff @(posedge sysClk)
    begin
        if (rxStrobe)
        begin
            case (state)
                waitOp:    opcode <= commandOp'(rxByte);
                waitRed:   red    <= rxByte;
                waitGreen: green  <= rxByte;
                waitBlue:  color  <= {red, green, rxByte};  // Lands with update
                default:   ;
            endcase
        end
    end

    // Commands are 4 bytes apart, so updates never touch
    updateSingle: assert property (@(posedge sysClk) disable iff (reset)
        update |=> !update);

endmodule

`default_nettype wire

/* verilog/patternGenerator.sv */
//------------------------------
// Pattern generator
// Scans a frame, emits test picture pixels
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module patternGenerator #(
    parameter int hDisplay = 640,
    parameter int vDisplay = 480
)(
    input  wire                                sysClk,
    input  wire                                reset,
    input  wire processerPkg::pictureMode      mode,
    input  wire [processerPkg::pixelWidth-1:0] color,
    input  wire                                update,
    pixelStreamIf.source                       pixelOut
);
    import processerPkg::*;

    localparam int xWidth   = $clog2(hDisplay);
    localparam int yWidth   = $clog2(vDisplay);
    localparam int barWidth = hDisplay / 8;
    localparam int barBits  = $clog2(barWidth + 1);

    pictureMode            pendMode;    // Last command seen
    pictureMode            actMode;     // Mode of the frame in flight
    pictureMode            nextMode;
    logic [pixelWidth-1:0] pendColor;
    logic [pixelWidth-1:0] actColor;
    logic [pixelWidth-1:0] nextColor;
    logic                  running;
    logic [xWidth-1:0]     x;
    logic [xWidth-1:0]     xTile;
    logic [yWidth-1:0]     y;
    logic [yWidth-1:0]     yTile;
    logic [barBits-1:0]    barPos;      // Position inside current bar
    logic [2:0]            barIdx;
    logic                  transfer;
    logic                  lineEnd;
    logic                  frameEnd;
    logic                  boundary;

    assign transfer  = pixelOut.valid && pixelOut.ready;
    assign lineEnd   = x == xWidth'(hDisplay - 1);
    assign frameEnd  = lineEnd && y == yWidth'(vDisplay - 1);
    assign boundary  = !running || (transfer && frameEnd);   // Safe point to switch
    assign nextMode  = update ? mode : pendMode;             // Same-cycle command wins
    assign nextColor = update ? color : pendColor;

    //------------------------------
    // Setting latch and scan
    //------------------------------
    always_ff @(posedge sysClk)
    begin
        if (reset)
        begin
            pendMode <= cmdStop;
            actMode  <= cmdStop;
            running  <= 1'b0;
            x        <= '0;
            y        <= '0;
            barPos   <= '0;
            barIdx   <= '0;
        end
        else
        begin
            if (update)
                pendMode <= mode;
            if (boundary)
            begin
                actMode <= nextMode;
                running <= nextMode != cmdStop;         // Stop idles the stream
            end
            if (transfer)
            begin
                if (lineEnd)
                begin
                    x      <= '0;
                    y      <= frameEnd ? '0 : y + 1'b1;
                    barPos <= '0;
                    barIdx <= '0;
                end
                else
                begin
                    x <= x + 1'b1;
                    if (barPos == barBits'(barWidth - 1))
                    begin
                        barPos <= '0;
                        barIdx <= barIdx + 1'b1;
                    end
                    else
                        barPos <= barPos + 1'b1;
                end
            end
        end
    end

    // Colour registers
    always_ff @(posedge sysClk)
    begin
        if (update)
            pendColor <= color;
        if (boundary)
            actColor <= nextColor;
    end

    assign xTile = x >> 3;     // 8x8 tile coordinates
    assign yTile = y >> 3;

    always_comb
    begin
        case (actMode)
            cmdSolid:   pixelOut.pixel = actColor;
            cmdBars:    pixelOut.pixel = {{8{barIdx[2]}}, {8{barIdx[1]}}, {8{barIdx[0]}}};
            cmdChecker: pixelOut.pixel = (xTile[0] ^ yTile[0]) ? ~actColor : actColor;
            default:    pixelOut.pixel = '0;
        endcase
    end

    assign pixelOut.valid = running;
    assign pixelOut.first = running && x == '0 && y == '0;

    // Stalled pixel must wait unchanged
    holdStable: assert property (@(posedge sysClk) disable iff (reset)
        pixelOut.valid && !pixelOut.ready |=>
            pixelOut.valid && $stable(pixelOut.pixel) && $stable(pixelOut.first));

endmodule

`default_nettype wire

/* verilog/pixelFifo.sv */
//------------------------------
// Pixel FIFO
// sysClk to pixelClk crossing, Gray pointers
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module pixelFifo #(
    parameter int fifoDepth = 1024      // Power of two
)(
    input  wire                                 sysClk,
    input  wire                                 pixelClk,
    input  wire                                 reset,
    pixelStreamIf.sink                          pixelIn,
    input  wire                                 pixelEnable,    // Video timing pull
    output logic [processerPkg::pixelWidth-1:0] pixel,
    output logic                                pixelFirst,
    output logic                                pixelValid
);
    import processerPkg::*;

    localparam int addrWidth  = $clog2(fifoDepth);
    localparam int entryWidth = pixelWidth + 1;     // Pixel plus first flag

    logic [entryWidth-1:0]      mem [fifoDepth];
    logic [entryWidth-1:0]      readEntry;
    logic [addrWidth:0]         wBin;               // Extra bit tells full from empty
    logic [addrWidth:0]         wBinNext;
    logic [addrWidth:0]         wGray;
    logic [addrWidth:0]         rBin;
    logic [addrWidth:0]         rBinNext;
    logic [addrWidth:0]         rGray;
    logic [1:0][addrWidth:0]    rGraySync;          // Read pointer into sysClk
    logic [1:0][addrWidth:0]    wGraySync;          // Write pointer into pixelClk
    logic [1:0]                 pixResetSync;
    logic                       pixReset;
    logic                       full;
    logic                       empty;
    logic                       write;
    logic                       read;

    //------------------------------
    // Write side, sysClk
    //------------------------------
    assign wBinNext      = wBin + 1'b1;
    assign full          = wGray == {~rGraySync[1][addrWidth:addrWidth-1],
                                     rGraySync[1][addrWidth-2:0]};
    assign pixelIn.ready = !full;
    assign write         = pixelIn.valid && !full;

    always_ff @(posedge sysClk)
    begin
        if (reset)
        begin
            wBin      <= '0;
            wGray     <= '0;
            rGraySync <= '0;
        end
        else
        begin
            rGraySync <= {rGraySync[0], rGray};
            if (write)
            begin
                wBin  <= wBinNext;
                wGray <= wBinNext ^ (wBinNext >> 1);
            end
        end
    end

    always_ff @(posedge sysClk)
    begin
        if (write)
            mem[wBin[addrWidth-1:0]] <= {pixelIn.first, pixelIn.pixel};
    end

    //------------------------------
    // Read side, pixelClk
    //------------------------------
    always_ff @(posedge pixelClk)
    begin
        pixResetSync <= {pixResetSync[0], reset};   // Local copy of reset
    end

    assign pixReset  = pixResetSync[1];
    assign rBinNext  = rBin + 1'b1;
    assign empty     = rGray == wGraySync[1];
    assign read      = pixelEnable && !empty;       // Empty pull is a no-op
    assign readEntry = mem[rBin[addrWidth-1:0]];

    always_ff @(posedge pixelClk)
    begin
        if (pixReset)
        begin
            rBin       <= '0;
            rGray      <= '0;
            wGraySync  <= '0;
            pixelValid <= 1'b0;
            pixelFirst <= 1'b0;
        end
        else
        begin
            wGraySync  <= {wGraySync[0], wGray};
            pixelValid <= read;
            pixelFirst <= read && readEntry[pixelWidth];
            if (read)
            begin
                rBin  <= rBinNext;
                rGray <= rBinNext ^ (rBinNext >> 1);
            end
        end
    end

    always_ff @(posedge pixelClk)
    begin
        if (read)
            pixel <= readEntry[pixelWidth-1:0];
    end

    // Write pointer frozen while full
    noOverflow: assert property (@(posedge sysClk) disable iff (reset)
        full |=> $stable(wBin));

endmodule

`default_nettype wire

/* verilog/processer.sv */
//------------------------------
// Processer display branch
// UART commands to test-picture pixel stream
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module processer #(
    parameter int clkDiv    = 868,      // 115200 baud at 100 MHz
    parameter int hDisplay  = 640,
    parameter int vDisplay  = 480,
    parameter int fifoDepth = 1024
)(
    input  wire                                sysClk,
    input  wire                                pixelClk,
    input  wire                                reset,       // Sync, active high
    input  wire                                uartRx,
    input  wire                                pixelEnable, // Video enable, pixelClk
    output wire [processerPkg::pixelWidth-1:0] pixel,
    output wire                                pixelFirst,
    output wire                                pixelValid
);
    import processerPkg::*;

    logic [7:0]            rxByte;
    logic                  rxStrobe;
    pictureMode            mode;
    logic [pixelWidth-1:0] color;
    logic                  update;

    pixelStreamIf pixelStream ();      // Generator to FIFO

    //------------------------------
    // Command path
    //------------------------------
    uartReceiver #(
        .clkDiv     (clkDiv)
    ) receiver (
        .sysClk     (sysClk),
        .reset      (reset),
        .uartRx     (uartRx),
        .rxByte     (rxByte),
        .rxStrobe   (rxStrobe)
    );

    commandParser parser (
        .sysClk     (sysClk),
        .reset      (reset),
        .rxByte     (rxByte),
        .rxStrobe   (rxStrobe),
        .mode       (mode),
        .color      (color),
        .update     (update)
    );

    //------------------------------
    // Pixel path
    //------------------------------
    patternGenerator #(
        .hDisplay   (hDisplay),
        .vDisplay   (vDisplay)
    ) generator (
        .sysClk     (sysClk),
        .reset      (reset),
        .mode       (mode),
        .color      (color),
        .update     (update),
        .pixelOut   (pixelStream.source)
    );

    pixelFifo #(
        .fifoDepth  (fifoDepth)
    ) fifo (
        .sysClk      (sysClk),
        .pixelClk    (pixelClk),
        .reset       (reset),
        .pixelIn     (pixelStream.sink),
        .pixelEnable (pixelEnable),
        .pixel       (pixel),
        .pixelFirst  (pixelFirst),
        .pixelValid  (pixelValid)
    );

endmodule

`default_nettype wire

/* bench/processerTb.sv */
//------------------------------
// Processer testbench
// UART commands in, pixel stream checked
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module processerTb;
    import processerPkg::*;

    localparam int hDisp       = 16;
    localparam int vDisp       = 4;
    localparam int frameSize   = hDisp * vDisp;
    localparam int bitCycles   = 8;         // sysClk cycles per UART bit
    localparam int sysPeriod   = 4;
    localparam int pixPeriod   = 6;
    localparam int drainCycles = 1500;      // pixelClk cycles to empty FIFO after stop
    localparam int idleCycles  = 300;       // Quiet window that must stay empty
    localparam int numSteps    = 9;

    typedef struct packed {
        logic [7:0]  op;
        logic        randomColor;
        logic [23:0] color;
        logic [7:0]  frames;                // Frames of the new picture to read
    } stepT;

    // Command sequence, each applied while the old picture keeps streaming
    localparam stepT steps [numSteps] = '{
        '{cmdSolid,   1'b1, 24'h000000, 8'd2},
        '{cmdBars,    1'b0, 24'h123456, 8'd2},  // Colour bytes ignored
        '{cmdChecker, 1'b0, 24'h3ca50f, 8'd2},
        '{cmdSolid,   1'b1, 24'h000000, 8'd2},
        '{8'h5a,      1'b0, 24'h000000, 8'd3},  // Junk opcode
        '{cmdChecker, 1'b1, 24'h000000, 8'd2},
        '{cmdStop,    1'b0, 24'h000000, 8'd0},
        '{cmdBars,    1'b0, 24'hffffff, 8'd2},  // Restart from idle
        '{cmdStop,    1'b0, 24'h000000, 8'd0}
    };

    logic                  sysClk;
    logic                  pixelClk;
    logic                  reset;
    logic                  uartRx;
    logic                  pixelEnable;
    logic [pixelWidth-1:0] pixel;
    logic                  pixelFirst;
    logic                  pixelValid;

    // Reference picture state
    logic [7:0]  curMode;                   // Picture in the frames being read
    logic [23:0] curColor;
    logic [7:0]  pendMode;                  // Commanded, not yet seen at a frame start
    logic [23:0] pendColor;
    logic        havePending;
    logic        oldAlive;                  // Frame so far matches current picture
    logic        newAlive;                  // Frame so far matches pending picture
    logic        readerOn;
    int          pos;                       // Scan position inside the frame
    int          framesCur;
    int          pixelCount;

    processer #(
        .clkDiv      (bitCycles),
        .hDisplay    (hDisp),
        .vDisplay    (vDisp),
        .fifoDepth   (16)
    ) i_dut (
        .sysClk      (sysClk),
        .pixelClk    (pixelClk),
        .reset       (reset),
        .uartRx      (uartRx),
        .pixelEnable (pixelEnable),
        .pixel       (pixel),
        .pixelFirst  (pixelFirst),
        .pixelValid  (pixelValid)
    );

    always #(sysPeriod / 2) sysClk = ~sysClk;
    always #(pixPeriod / 2) pixelClk = ~pixelClk;

    //------------------------------
    // Helpers
    //------------------------------
    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string name);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0d ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "check on %s failed", name);
        end
    endtask

    // Picture rules for position x, y
    function automatic logic [23:0] expectedPixel(input logic [7:0] op,
                                                  input logic [23:0] color,
                                                  input int x, input int y);
        int bar;
        bar = x / (hDisp / 8);
        case (op)
            cmdSolid:   return color;
            cmdBars:    return {bar[2] ? 8'hff : 8'h00,
                                bar[1] ? 8'hff : 8'h00,
                                bar[0] ? 8'hff : 8'h00};
            cmdChecker: return ((x / 8 + y / 8) % 2 == 1) ? ~color : color;
            default:    return 24'h000000;
        endcase
    endfunction

    // 8N1, LSB first
    task automatic sendByte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(posedge sysClk);
            #1 uartRx = frame[i];
            repeat (bitCycles - 1) @(posedge sysClk);
        end
    endtask

    task automatic sendCommand(input logic [7:0] op, input logic [23:0] color);
        sendByte(op);
        sendByte(color[23:16]);     // Red
        sendByte(color[15:8]);
        sendByte(color[7:0]);
    endtask

    task automatic driveEnable();
        forever
        begin
            @(posedge pixelClk);
            #1 pixelEnable = ($urandom % 3) == 0;   // Mostly low, FIFO runs full
        end
    endtask

    //------------------------------
    // Pixel reader
    //------------------------------
    task automatic takePixel();
        int          x;
        int          y;
        logic [23:0] oldPix;
        logic [23:0] newPix;
        logic        wasOld;
        logic        wasNew;

        x = pos % hDisp;
        y = pos / hDisp;
        check(pixelFirst, pos == 0, "pixelFirst");
        if (pos == 0)
        begin
            oldAlive = curMode != cmdStop;          // Switch allowed only here
            newAlive = havePending && pendMode != cmdStop;
        end
        wasOld = oldAlive;
        wasNew = newAlive;
        if (!wasOld && !wasNew)
            check(pixelValid, 1'b0, "pixelValid"); // Nothing should stream
        oldPix   = expectedPixel(curMode, curColor, x, y);
        newPix   = expectedPixel(pendMode, pendColor, x, y);
        oldAlive = wasOld && pixel === oldPix;
        newAlive = wasNew && pixel === newPix;
        if (!oldAlive && !newAlive)
            check(pixel, wasNew ? newPix : oldPix, "pixel");
        pixelCount++;
        if (pos == frameSize - 1)
        begin
            pos = 0;
            if (newAlive)
            begin
                curMode     = pendMode;             // Whole frame was the new picture
                curColor    = pendColor;
                havePending = 1'b0;
                framesCur   = 1;
            end
            else
                framesCur++;
        end
        else
            pos++;
    endtask

    // Outputs settle on posedge, sample mid-cycle
    always @(negedge pixelClk)
    begin
        if (readerOn && pixelValid)
            takePixel();
    end

    //------------------------------
    // Main sequence
    //------------------------------
    initial
    begin : mainFlow
        stepT        step;
        logic [23:0] color;
        int          seen;

        sysClk      = 1'b0;
        pixelClk    = 1'b0;
        reset       = 1'b1;
        uartRx      = 1'b1;                         // Line idle
        pixelEnable = 1'b0;
        curMode     = cmdStop;
        curColor    = '0;
        pendMode    = cmdStop;
        pendColor   = '0;
        havePending = 1'b0;
        oldAlive    = 1'b0;
        newAlive    = 1'b0;
        readerOn    = 1'b0;
        pos         = 0;
        framesCur   = 0;
        pixelCount  = 0;
        void'($urandom(32'h4ff7_0ec0));
        fork
            driveEnable();
        join_none
        repeat (4) @(posedge sysClk);
        #1 reset = 1'b0;
        repeat (4) @(posedge pixelClk);
        readerOn = 1'b1;

        for (int i = 0; i < numSteps; i++)
        begin
            step  = steps[i];
            color = step.randomColor ? 24'($urandom) : step.color;
            @(posedge sysClk);
            #1;
            if (!(step.op inside {cmdStop, cmdSolid, cmdBars, cmdChecker}))
            begin
                framesCur = 0;
                sendByte(step.op);                  // Lone byte, colours would parse as ops
                wait (framesCur >= step.frames);
            end
            else if (step.op == cmdStop)
            begin
                pendMode    = step.op;
                havePending = 1'b1;                 // Current frame still completes
                sendCommand(step.op, color);
                repeat (drainCycles) @(posedge pixelClk);
                seen = pixelCount;
                repeat (idleCycles) @(posedge pixelClk);
                check(pixelCount, seen, "pixelCount after stop");
                check(pos, 0, "frame position after stop");
                curMode     = cmdStop;
                havePending = 1'b0;
            end
            else
            begin
                pendMode    = step.op;
                pendColor   = color;
                havePending = 1'b1;
                sendCommand(step.op, color);
                wait (!havePending && framesCur >= step.frames);
            end
        end

        $display("All tests passed");
        $finish;
    end

    // Budget from table length
    initial
    begin : watchdog
        longint limitNs;
        int     frameBudget;
        int     stops;

        frameBudget = 0;
        stops       = 0;
        for (int i = 0; i < numSteps; i++)
        begin
            frameBudget += steps[i].frames + 2;     // Up to two old frames first
            if (steps[i].op == cmdStop)
                stops++;
        end
        limitNs = longint'(frameBudget) * frameSize * pixPeriod * 3 * 4
                + numSteps * 4 * 10 * bitCycles * sysPeriod
                + stops * (drainCycles + idleCycles) * pixPeriod + 1000;
        #(limitNs);
        $display("Timeout after %0d ns, the pixel stream did not deliver the frames", limitNs);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* processer.f */
verilog/processerPkg.sv
verilog/pixelStreamIf.sv
verilog/uartReceiver.sv
verilog/commandParser.sv
verilog/patternGenerator.sv
verilog/pixelFifo.sv
verilog/processer.sv
bench/processerTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := processerTb
FILELIST   := processer.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
